// File: src/trig_pkg.sv
// Trigger path shared definitions
package trig_pkg;

  localparam int num_chan    = 5;
  localparam int burst_w     = 23;
  localparam int ddr3_limit  = 524288;  // async burst capacity per channel
  localparam int trig_num_w  = 24;
  localparam int timestamp_w = 44;
  localparam int length_w    = 2;
  localparam int fifo_depth  = 8;
  localparam int fifo_cnt_w  = 4;

  // one-hot state bit positions
  localparam int st_idle  = 0;
  localparam int st_wait  = 1;
  localparam int st_ready = 2;
  localparam int st_store = 3;
  localparam int st_rearm = 4;

  localparam logic [length_w-1:0] len_none  = 2'd0;
  localparam logic [length_w-1:0] len_short = 2'd1;
  localparam logic [length_w-1:0] len_long  = 2'd2;
  localparam logic [length_w-1:0] len_mixed = 2'd3;

  typedef struct packed {
    logic [127-length_w-trig_num_w-timestamp_w:0] pad;
    logic [length_w-1:0]    length;
    logic [trig_num_w-1:0]  trig_num;
    logic [timestamp_w-1:0] timestamp;  // low end
  } trig_info_t;

  // record as fields, or as four bus words (word 0 lowest)
  typedef union packed {
    trig_info_t       f;
    logic [3:0][31:0] w;
  } trig_info_u;

  localparam logic [7:0] reg_ctrl    = 8'h00;
  localparam logic [7:0] reg_thres   = 8'h04;
  localparam logic [7:0] reg_burst0  = 8'h08;
  localparam logic [7:0] reg_burst1  = 8'h0C;
  localparam logic [7:0] reg_burst2  = 8'h10;
  localparam logic [7:0] reg_burst3  = 8'h14;
  localparam logic [7:0] reg_burst4  = 8'h18;
  localparam logic [7:0] reg_ovf     = 8'h1C;
  localparam logic [7:0] reg_status  = 8'h20;
  localparam logic [7:0] reg_trignum = 8'h24;
  localparam logic [7:0] reg_fifo0   = 8'h28;
  localparam logic [7:0] reg_fifo1   = 8'h2C;
  localparam logic [7:0] reg_fifo2   = 8'h30;
  localparam logic [7:0] reg_fifo3   = 8'h34;
  localparam logic [7:0] reg_cmd     = 8'h38;
  localparam logic [7:0] reg_stored0 = 8'h40;
  localparam logic [7:0] reg_stored1 = 8'h44;
  localparam logic [7:0] reg_stored2 = 8'h48;
  localparam logic [7:0] reg_stored3 = 8'h4C;
  localparam logic [7:0] reg_stored4 = 8'h50;

endpackage

// File: src/pulse_trigger_receiver.sv
// Front panel trigger receiver
// asynchronous mode
`timescale 1ns/100ps

module pulse_trigger_receiver (
  input  logic clk,
  input  logic reset,
  input  logic reset_trig_num,         // TTC channel B resets
  input  logic reset_trig_timestamp,
  input  logic trigger,                // front panel level
  input  logic [3:0] fp_trig_width,    // short/long boundary in cycles
  input  logic accept_pulse_triggers,
  input  logic async_mode,
  input  logic ddr3_full,
  input  logic fifo_ready,
  input  logic readout_done,
  output logic pulse_trigger,          // to the channels
  output logic [trig_pkg::trig_num_w-1:0] trig_num,
  output logic fifo_valid,
  output trig_pkg::trig_info_u fifo_data,
  output logic [trig_pkg::st_rearm:0] state,
  output logic [31:0] ddr3_overflow_count
);
  import trig_pkg::*;

  logic [st_rearm:0] next_state;
  logic next_pulse;
  logic went_lo;
  logic next_went_lo;
  logic [3:0] wait_cnt;
  logic [3:0] next_wait_cnt;
  logic [length_w-1:0] trig_len;
  logic [length_w-1:0] next_trig_len;
  logic [timestamp_w-1:0] ts_cnt;     // free running
  logic [timestamp_w-1:0] ts_latch;   // taken at acceptance
  logic qualified;
  logic accept;
  logic drop;

  assign qualified = trigger & async_mode & accept_pulse_triggers;
  assign accept    = state[st_idle] & qualified & ~ddr3_full;
  assign drop      = state[st_idle] & qualified & ddr3_full;  // would overrun DDR3

  always_comb begin
    next_state    = '0;
    next_pulse    = 1'b0;
    next_went_lo  = went_lo;
    next_wait_cnt = wait_cnt;
    next_trig_len = trig_len;
    unique case (1'b1)
      state[st_idle]: begin
        if (accept) begin
          next_pulse    = 1'b1;
          next_went_lo  = 1'b0;
          next_wait_cnt = 4'd1;
          next_trig_len = len_none;
          next_state[st_wait] = 1'b1;
        end else if (drop) begin
          next_state[st_rearm] = 1'b1;  // count a dropped trigger once
        end else begin
          next_state[st_idle] = 1'b1;
        end
      end
      state[st_wait]: begin
        if (wait_cnt >= fp_trig_width) begin
          // classify from level now and any low seen so far
          if (!trigger)
            next_trig_len = len_short;
          else if (went_lo)
            next_trig_len = len_mixed;
          else
            next_trig_len = len_long;
          next_state[st_ready] = 1'b1;
        end else begin
          next_wait_cnt = wait_cnt + 4'd1;
          if (!trigger)
            next_went_lo = 1'b1;
          next_state[st_wait] = 1'b1;
        end
      end
      state[st_ready]: next_state[st_store] = 1'b1;
      state[st_store]: begin
        if (!fifo_ready)
          next_state[st_store] = 1'b1;  // back-pressure
        else if (trigger)
          next_state[st_rearm] = 1'b1;
        else
          next_state[st_idle] = 1'b1;
      end
      state[st_rearm]: begin
        if (trigger)
          next_state[st_rearm] = 1'b1;
        else
          next_state[st_idle] = 1'b1;
      end
      default: next_state[st_idle] = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state               <= '0;
      state[st_idle]      <= 1'b1;
      pulse_trigger       <= 1'b0;
      fifo_valid          <= 1'b0;
      went_lo             <= 1'b0;
      wait_cnt            <= '0;
      trig_len            <= len_none;
      ddr3_overflow_count <= '0;
    end else begin
      state         <= next_state;
      pulse_trigger <= next_pulse;
      fifo_valid    <= next_state[st_store];
      went_lo       <= next_went_lo;
      wait_cnt      <= next_wait_cnt;
      trig_len      <= next_trig_len;
      if (drop)
        ddr3_overflow_count <= ddr3_overflow_count + 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || reset_trig_num || readout_done)
      trig_num <= '0;
    else if (next_pulse)
      trig_num <= trig_num + 1'b1;  // first trigger is number 1

    if (reset || reset_trig_timestamp)
      ts_cnt <= '0;
    else
      ts_cnt <= ts_cnt + 1'b1;
  end

  // record payload
  always_ff @(posedge clk) begin
    if (accept)
      ts_latch <= ts_cnt;
    if (state[st_ready]) begin
      fifo_data.f.pad       <= '0;
      fifo_data.f.length    <= trig_len;
      fifo_data.f.trig_num  <= trig_num;
      fifo_data.f.timestamp <= ts_latch;
    end
  end

  a_state_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(state));

  // record must not change or vanish while the FIFO stalls
  a_valid_held: assert property (@(posedge clk) disable iff (reset)
    fifo_valid && !fifo_ready |=> fifo_valid && $stable(fifo_data));

endmodule

// File: src/burst_occupancy_tracker.sv
// DDR3 burst occupancy per channel
`timescale 1ns/100ps

module burst_occupancy_tracker (
  input  logic clk,
  input  logic reset,
  input  logic readout_done,
  input  logic pulse_trigger,
  input  logic [trig_pkg::num_chan-1:0] chan_en,
  input  logic [trig_pkg::burst_w-1:0] thres_ddr3_overflow,
  input  logic [trig_pkg::burst_w-1:0] burst_count_chan0,
  input  logic [trig_pkg::burst_w-1:0] burst_count_chan1,
  input  logic [trig_pkg::burst_w-1:0] burst_count_chan2,
  input  logic [trig_pkg::burst_w-1:0] burst_count_chan3,
  input  logic [trig_pkg::burst_w-1:0] burst_count_chan4,
  output logic [trig_pkg::burst_w-1:0] stored_bursts_chan0,
  output logic [trig_pkg::burst_w-1:0] stored_bursts_chan1,
  output logic [trig_pkg::burst_w-1:0] stored_bursts_chan2,
  output logic [trig_pkg::burst_w-1:0] stored_bursts_chan3,
  output logic [trig_pkg::burst_w-1:0] stored_bursts_chan4,
  output logic ddr3_full,
  output logic ddr3_almost_full
);
  import trig_pkg::*;

  logic [burst_w-1:0] burst_cnt [num_chan];
  logic [burst_w-1:0] stored [num_chan];
  logic [burst_w:0] incr [num_chan];  // count + 1 may carry out
  logic [num_chan-1:0] full_ch;
  logic [num_chan-1:0] warn_ch;

  assign burst_cnt[0] = burst_count_chan0;
  assign burst_cnt[1] = burst_count_chan1;
  assign burst_cnt[2] = burst_count_chan2;
  assign burst_cnt[3] = burst_count_chan3;
  assign burst_cnt[4] = burst_count_chan4;

  assign stored_bursts_chan0 = stored[0];
  assign stored_bursts_chan1 = stored[1];
  assign stored_bursts_chan2 = stored[2];
  assign stored_bursts_chan3 = stored[3];
  assign stored_bursts_chan4 = stored[4];

  always_comb begin
    for (int i = 0; i < num_chan; i++) begin
      incr[i] = chan_en[i] ? {1'b0, burst_cnt[i]} + 1'b1 : '0;
      // same as limit - stored < incr, without the wrap
      full_ch[i] = ({1'b0, stored[i]} + incr[i]) > ddr3_limit;
      warn_ch[i] = stored[i] > thres_ddr3_overflow;
    end
  end

  assign ddr3_full        = |full_ch;
  assign ddr3_almost_full = |warn_ch;

  always_ff @(posedge clk) begin
    for (int i = 0; i < num_chan; i++) begin
      if (reset || readout_done)
        stored[i] <= '0;  // readout frees the DDR3
      else if (pulse_trigger)
        stored[i] <= stored[i] + incr[i][burst_w-1:0];
    end
  end

endmodule

// File: src/trig_info_fifo.sv
// Trigger information FIFO
`timescale 1ns/100ps

module trig_info_fifo (
  input  logic clk,
  input  logic reset,
  input  logic wr_valid,
  input  trig_pkg::trig_info_u wr_data,
  input  logic pop,
  output logic wr_ready,
  output trig_pkg::trig_info_u head_data,
  output logic [trig_pkg::fifo_cnt_w-1:0] level
);
  import trig_pkg::*;

  trig_info_u mem [fifo_depth];
  logic [fifo_cnt_w-2:0] wr_ptr;  // wraps at depth
  logic [fifo_cnt_w-2:0] rd_ptr;
  logic push;
  logic pull;

  assign wr_ready  = level != fifo_cnt_w'(fifo_depth);
  assign push      = wr_valid & wr_ready;
  assign pull      = pop & (level != '0);  // pop on empty is ignored
  assign head_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pull)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pull})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  a_level_bound: assert property (@(posedge clk) disable iff (reset) level <= fifo_depth);

endmodule

// File: src/wb_trig_regs.sv
// Wishbone register slave for the trigger path
`timescale 1ns/100ps

module wb_trig_regs (
  input  logic clk,
  input  logic reset,
  input  logic wb_cyc,
  input  logic wb_stb,
  input  logic wb_we,
  input  logic [7:0] wb_adr,
  input  logic [31:0] wb_dat_i,
  input  trig_pkg::trig_info_u fifo_head,
  input  logic [trig_pkg::fifo_cnt_w-1:0] fifo_level,
  input  logic [trig_pkg::st_rearm:0] state,
  input  logic [trig_pkg::trig_num_w-1:0] trig_num,
  input  logic [31:0] ddr3_overflow_count,
  input  logic [trig_pkg::burst_w-1:0] stored_bursts_chan0,
  input  logic [trig_pkg::burst_w-1:0] stored_bursts_chan1,
  input  logic [trig_pkg::burst_w-1:0] stored_bursts_chan2,
  input  logic [trig_pkg::burst_w-1:0] stored_bursts_chan3,
  input  logic [trig_pkg::burst_w-1:0] stored_bursts_chan4,
  input  logic ddr3_almost_full,
  output logic [31:0] wb_dat_o,
  output logic wb_ack,
  output logic accept_pulse_triggers,
  output logic async_mode,
  output logic [3:0] fp_trig_width,
  output logic [trig_pkg::num_chan-1:0] chan_en,
  output logic [trig_pkg::burst_w-1:0] thres_ddr3_overflow,
  output logic [trig_pkg::burst_w-1:0] burst_count_chan0,
  output logic [trig_pkg::burst_w-1:0] burst_count_chan1,
  output logic [trig_pkg::burst_w-1:0] burst_count_chan2,
  output logic [trig_pkg::burst_w-1:0] burst_count_chan3,
  output logic [trig_pkg::burst_w-1:0] burst_count_chan4,
  output logic fifo_pop,
  output logic readout_done,
  output logic reset_trig_num,
  output logic reset_trig_timestamp
);
  import trig_pkg::*;

  logic access;  // first cycle of a bus cycle
  logic cmd_wr;
  logic [burst_w-1:0] burst_reg [num_chan];
  logic [burst_w-1:0] stored [num_chan];
  logic [2:0] burst_idx;
  logic [2:0] stored_idx;
  logic [1:0] fifo_idx;
  logic [31:0] rd_data;

  assign access     = wb_cyc & wb_stb & ~wb_ack;
  assign cmd_wr     = access & wb_we & (wb_adr == reg_cmd);
  assign burst_idx  = 3'((wb_adr - reg_burst0) >> 2);
  assign stored_idx = 3'((wb_adr - reg_stored0) >> 2);
  assign fifo_idx   = 2'((wb_adr - reg_fifo0) >> 2);

  assign burst_count_chan0 = burst_reg[0];
  assign burst_count_chan1 = burst_reg[1];
  assign burst_count_chan2 = burst_reg[2];
  assign burst_count_chan3 = burst_reg[3];
  assign burst_count_chan4 = burst_reg[4];
  assign stored[0] = stored_bursts_chan0;
  assign stored[1] = stored_bursts_chan1;
  assign stored[2] = stored_bursts_chan2;
  assign stored[3] = stored_bursts_chan3;
  assign stored[4] = stored_bursts_chan4;

  always_ff @(posedge clk) begin
    if (reset) begin
      accept_pulse_triggers <= 1'b0;
      async_mode            <= 1'b0;
      fp_trig_width         <= '0;
      chan_en               <= '0;
      thres_ddr3_overflow   <= '0;
      for (int i = 0; i < num_chan; i++)
        burst_reg[i] <= '0;
    end else if (access && wb_we) begin
      case (wb_adr)
        reg_ctrl: begin
          accept_pulse_triggers <= wb_dat_i[0];
          async_mode            <= wb_dat_i[1];
          fp_trig_width         <= wb_dat_i[7:4];
          chan_en               <= wb_dat_i[12:8];
        end
        reg_thres: thres_ddr3_overflow <= wb_dat_i[burst_w-1:0];
        reg_burst0, reg_burst1, reg_burst2, reg_burst3, reg_burst4:
          burst_reg[burst_idx] <= wb_dat_i[burst_w-1:0];
        default: ;
      endcase
    end
  end

  // ack and command strobes, one cycle each
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack               <= 1'b0;
      fifo_pop             <= 1'b0;
      readout_done         <= 1'b0;
      reset_trig_num       <= 1'b0;
      reset_trig_timestamp <= 1'b0;
    end else begin
      wb_ack               <= access;
      fifo_pop             <= cmd_wr & wb_dat_i[0];
      readout_done         <= cmd_wr & wb_dat_i[1];
      reset_trig_num       <= cmd_wr & wb_dat_i[2];
      reset_trig_timestamp <= cmd_wr & wb_dat_i[3];
    end
  end

  always_comb begin
    case (wb_adr)
      reg_ctrl:
        rd_data = {19'd0, chan_en, fp_trig_width, 2'd0, async_mode, accept_pulse_triggers};
      reg_thres:   rd_data = 32'(thres_ddr3_overflow);
      reg_burst0, reg_burst1, reg_burst2, reg_burst3, reg_burst4:
        rd_data = 32'(burst_reg[burst_idx]);
      reg_ovf:     rd_data = ddr3_overflow_count;
      // almost_full at 16, level at 11:8, state at 4:0
      reg_status:  rd_data = {15'd0, ddr3_almost_full, 4'd0, fifo_level, 3'd0, state};
      reg_trignum: rd_data = 32'(trig_num);
      reg_fifo0, reg_fifo1, reg_fifo2, reg_fifo3:
        rd_data = fifo_head.w[fifo_idx];  // word view of the head record
      reg_stored0, reg_stored1, reg_stored2, reg_stored3, reg_stored4:
        rd_data = 32'(stored[stored_idx]);
      default:     rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (access)
      wb_dat_o <= rd_data;  // valid with ack
  end

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> wb_cyc && wb_stb);

endmodule

// File: src/trig_receiver_top.sv
// Async front panel trigger path top
`timescale 1ns/100ps

module trig_receiver_top (
  input  logic clk,
  input  logic reset,
  input  logic trigger,        // front panel
  output logic pulse_trigger,  // to the channels
  input  logic wb_cyc,
  input  logic wb_stb,
  input  logic wb_we,
  input  logic [7:0] wb_adr,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic wb_ack
);
  import trig_pkg::*;

  logic accept_pulse_triggers;
  logic async_mode;
  logic [3:0] fp_trig_width;
  logic [num_chan-1:0] chan_en;
  logic [burst_w-1:0] thres_ddr3_overflow;
  logic [burst_w-1:0] burst_count_chan0, burst_count_chan1, burst_count_chan2;
  logic [burst_w-1:0] burst_count_chan3, burst_count_chan4;
  logic [burst_w-1:0] stored_bursts_chan0, stored_bursts_chan1, stored_bursts_chan2;
  logic [burst_w-1:0] stored_bursts_chan3, stored_bursts_chan4;
  logic ddr3_full;
  logic ddr3_almost_full;
  logic readout_done;
  logic reset_trig_num;
  logic reset_trig_timestamp;
  logic [trig_num_w-1:0] trig_num;
  logic [st_rearm:0] state;
  logic [31:0] ddr3_overflow_count;
  logic fifo_valid;
  logic fifo_ready;
  logic fifo_pop;
  trig_info_u fifo_data;
  trig_info_u fifo_head;
  logic [fifo_cnt_w-1:0] fifo_level;

  // net names match the port names of the submodules
  pulse_trigger_receiver receiver0 (.*);

  burst_occupancy_tracker tracker0 (.*);

  trig_info_fifo fifo0 (
    .clk       (clk),
    .reset     (reset),
    .wr_valid  (fifo_valid),
    .wr_data   (fifo_data),
    .pop       (fifo_pop),
    .wr_ready  (fifo_ready),
    .head_data (fifo_head),
    .level     (fifo_level)
  );

  wb_trig_regs regs0 (.*);

endmodule

// File: testbench/trig_checker.sv
// Response checker for the trigger path
`timescale 1ns/100ps

module trig_checker (
  input  logic clk,
  input  logic reset,
  input  logic wb_ack,
  input  logic [7:0] wb_adr,
  input  logic [31:0] wb_dat_o,
  input  logic exp_valid,
  input  logic [1:0] exp_mode,
  input  logic [31:0] exp_data,
  input  logic pulse_trigger,
  input  logic [31:0] pulse_expect,
  input  logic run_done,
  output int error_count
);

  logic [31:0] last_read;  // last kept read value, for ordering checks
  int pulse_count;
  logic count_checked;

  always @(posedge clk) begin
    if (reset) begin
      error_count   <= 0;
      pulse_count   <= 0;
      last_read     <= '0;
      count_checked <= 1'b0;
    end else begin
      if (pulse_trigger)
        pulse_count <= pulse_count + 1;

      if (wb_ack && exp_valid) begin
        if (exp_mode != 2'd0)
          last_read <= wb_dat_o;  // only ordered reads form the chain
        case (exp_mode)
          2'd0: if (wb_dat_o !== exp_data) begin
            $display("Error: wb_dat_o at reg 0x%02h is 0x%08h, expected 0x%08h",
                     wb_adr, wb_dat_o, exp_data);
            error_count <= error_count + 1;
          end
          2'd1: if ((wb_dat_o > last_read) !== 1'b1) begin
            $display("Error: wb_dat_o at reg 0x%02h is 0x%08h, expected above 0x%08h",
                     wb_adr, wb_dat_o, last_read);
            error_count <= error_count + 1;
          end
          2'd2: if ((wb_dat_o < last_read) !== 1'b1) begin
            $display("Error: wb_dat_o at reg 0x%02h is 0x%08h, expected below 0x%08h",
                     wb_adr, wb_dat_o, last_read);
            error_count <= error_count + 1;
          end
          default: ;  // value only kept for the next compare
        endcase
      end

      // total pulses against the count the stimulus declares
      if (run_done && !count_checked) begin
        count_checked <= 1'b1;
        if (pulse_count != pulse_expect) begin
          $display("Error: pulse_trigger count is 0x%0h, expected 0x%0h",
                   pulse_count, pulse_expect);
          error_count <= error_count + 1;
        end
      end
    end
  end

endmodule

// File: testbench/tb_trig_receiver.sv
// Trigger path testbench
`timescale 1ns/100ps

module tb_trig_receiver;

  localparam string stim_file = "testbench/trig_stim.txt";

  logic clk;
  logic reset;
  logic trigger;
  logic pulse_trigger;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [7:0] wb_adr;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic wb_ack;
  logic exp_valid;
  logic [1:0] exp_mode;   // 0 equal, 1 above last, 2 below last, 3 record only
  logic [31:0] exp_data;
  logic [31:0] pulse_expect;
  logic run_done;
  int error_count;
  int cycle_limit = 0;
  int cycle_cnt = 0;

  trig_receiver_top dut0 (.*);

  trig_checker checker0 (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ends a run that stalls, e.g. on a missing ack
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("timeout: the stimulus did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // numbers of t, i and p lines are decimal, the rest hex
  function automatic void read_fields(input logic [8*80-1:0] line, output logic [31:0] op,
                                      output logic [31:0] a, output logic [31:0] b,
                                      output logic [31:0] c);
    int n;
    op = '0;
    a  = '0;
    b  = '0;
    c  = 32'd1;  // repeat count when absent
    n  = $sscanf(line, "%s %h %h %h", op, a, b, c);
    if (op == "t" || op == "i" || op == "p")
      n = $sscanf(line, "%s %d %d %d", op, a, b, c);
  endfunction

  function automatic int stim_cost();
    logic [8*80-1:0] line;
    logic [31:0] op, a, b, c;
    int fd;
    int cost;
    cost = 0;
    fd = $fopen(stim_file, "r");
    while (fd != 0 && !$feof(fd)) begin
      line = '0;
      if ($fgets(line, fd) != 0) begin
        read_fields(line, op, a, b, c);
        if (op == "t")
          cost += (a + b) * c;
        else if (op == "i")
          cost += a;
        else if (op == "w" || op == "r" || op == "n" || op == "g" || op == "l")
          cost += 3;  // bus access plus release
      end
    end
    if (fd != 0)
      $fclose(fd);
    return cost;
  endfunction

  task automatic bus_access(input logic we, input logic [7:0] adr, input logic [31:0] data,
                            input logic [1:0] mode);
    @(posedge clk);
    wb_cyc    <= 1'b1;
    wb_stb    <= 1'b1;
    wb_we     <= we;
    wb_adr    <= adr;
    wb_dat_i  <= we ? data : 32'd0;
    exp_valid <= ~we;
    exp_mode  <= mode;
    exp_data  <= data;
    @(posedge clk);
    while (!wb_ack)
      @(posedge clk);
    wb_cyc    <= 1'b0;
    wb_stb    <= 1'b0;
    wb_we     <= 1'b0;
    exp_valid <= 1'b0;
  endtask

  task automatic drive_trigger(input int high, input int low, input int times);
    repeat (times) begin
      repeat (high) @(posedge clk) trigger <= 1'b1;
      repeat (low) @(posedge clk) trigger <= 1'b0;
    end
  endtask

  task automatic run_stim(input int fd);
    logic [8*80-1:0] line;
    logic [31:0] op, a, b, c;
    while (!$feof(fd)) begin
      line = '0;
      if ($fgets(line, fd) != 0) begin
        read_fields(line, op, a, b, c);
        case (op)
          "w": bus_access(1'b1, a[7:0], b, 2'd0);
          "r": bus_access(1'b0, a[7:0], b, 2'd0);
          "g": bus_access(1'b0, a[7:0], 32'd0, 2'd1);
          "l": bus_access(1'b0, a[7:0], 32'd0, 2'd2);
          "n": bus_access(1'b0, a[7:0], 32'd0, 2'd3);
          "t": drive_trigger(a, b, c);
          "i": repeat (a) @(posedge clk);
          "p": pulse_expect <= a;
          default: ;  // comments and blank lines
        endcase
      end
    end
  endtask

  initial begin : main
    int fd;
    reset        = 1'b1;
    trigger      = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_i     = '0;
    exp_valid    = 1'b0;
    exp_mode     = '0;
    exp_data     = '0;
    pulse_expect = '0;
    run_done     = 1'b0;
    fd = $fopen(stim_file, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", stim_file);
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      cycle_limit = 4 * (16 + stim_cost());
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      run_stim(fd);
      $fclose(fd);
      repeat (4) @(posedge clk);
      run_done <= 1'b1;
      repeat (3) @(posedge clk);  // checker closes its pulse count
      $display("checks done, %0d errors", error_count);
      if (error_count == 0)
        $display("*** TEST PASSED ***");
      else
        $display("*** TEST FAILED ***");
      $finish;
    end
  end

endmodule

// File: project.f
src/trig_pkg.sv
src/pulse_trigger_receiver.sv
src/burst_occupancy_tracker.sv
src/trig_info_fifo.sv
src/wb_trig_regs.sv
src/trig_receiver_top.sv
testbench/trig_checker.sv
testbench/tb_trig_receiver.sv

// File: testbench/trig_stim.txt
# w adr data = write, r adr data = read and compare, n/g/l adr = read kept/above/below last
# t high low [times] = trigger cycles, i n = idle cycles, p n = total pulses (decimal)
p 16
w 00 00000063
t 2 12
t 10 4
t 2 1
t 5 12
r 24 00000003
r 20 00000301
r 30 00000010
r 2c 00001000
n 28
w 38 00000001
r 30 00000020
r 2c 00002000
g 28
w 38 00000001
r 30 00000030
r 2c 00003000
g 28
w 38 00000001
w 38 00000008
t 2 12
l 28
w 38 00000001
w 04 00000100
w 08 00000003
w 10 00000007
w 00 00000563
t 2 12 2
r 40 00000008
r 44 00000000
r 48 00000010
r 4c 00000000
r 50 00000000
r 24 00000006
w 38 00000003
w 38 00000001
r 40 00000000
r 48 00000000
r 24 00000000
w 08 0007ffff
t 2 12 2
r 1c 00000001
r 40 00080000
r 20 00010101
w 38 00000003
w 00 00000561
t 2 12
w 00 00000562
t 2 12
r 20 00000001
w 00 00000003
t 1 3 9
r 20 00000808
r 24 00000009
w 38 00000001
r 20 00000801
r 2c 00002000
i 8
